/* list.f */
+incdir+verilog
verilog/pcw_board_pkg.sv
verilog/host_link.sv
verilog/event_toggle.sv
verilog/sector_store.sv
verilog/audio_i2s.sv
verilog/pcw_board.sv
verification/pcw_board_checker.sv
verification/tb_pcw_board.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the board testbench with Verilator from the project root
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pcw_board \
	-f list.f -o sim_pcw_board > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/sim_pcw_board > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TEST PASS" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

/* verification/pcw_board_checker.sv */
module pcw_board_checker (
	input logic clk_sys,
	input logic [31:0] status,
	input logic core_reset,
	input logic [10:0] ps2_key,
	input logic [24:0] ps2_mouse,
	input logic [7:0] core_rd_data,
	input logic core_rd_valid,
	input logic i2s_bck,
	input logic i2s_lrck,
	input logic i2s_data
);

	int pass_count = 0;
	int fail_count = 0;

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp === act) begin
			pass_count++;
			$display("[PASS] %s", name);
		end else begin
			fail_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_missing(input string name, input string what);
		fail_count++;
		$display("%s: %s", name, what);
	endtask

	// Status settles one cycle after the last frame byte
	task automatic check_status(input string name, input logic [31:0] exp_status,
		input logic exp_reset);
		repeat (2) @(negedge clk_sys);
		compare(name, {31'd0, exp_reset, exp_status}, {31'd0, core_reset, status});
	endtask

	// Mouse when is_mouse is set, keys otherwise
	task automatic check_event(input string name, input logic is_mouse, input logic [24:0] exp);
		logic old_level;
		logic seen;
		old_level = is_mouse ? ps2_mouse[24] : ps2_key[10];
		seen = 1'b0;
		for (int i = 0; i < 4 && !seen; i++) begin
			@(negedge clk_sys);
			seen = (is_mouse ? ps2_mouse[24] : ps2_key[10]) != old_level;
		end
		if (!seen)
			report_missing(name, "the event level bit never flipped");
		else if (is_mouse)
			compare(name, {39'd0, exp}, {39'd0, ps2_mouse});
		else
			compare(name, {53'd0, exp[10:0]}, {53'd0, ps2_key});
	endtask

	// A read is answered within three cycles, even after losing to a write
	task automatic check_read(input string name, input logic [7:0] exp);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < 4 && !seen; i++) begin
			@(negedge clk_sys);
			seen = core_rd_valid;
		end
		if (!seen)
			report_missing(name, "core_rd_valid did not come within three cycles");
		else
			compare(name, {56'd0, exp}, {56'd0, core_rd_data});
	endtask

	// One whole frame from the falling word select, sampled on rising bit clock
	task automatic check_audio(input string name, input logic [15:0] exp);
		logic [63:0] frame;
		@(negedge i2s_lrck);
		for (int i = 63; i >= 0; i--) begin
			@(posedge i2s_bck);
			frame[i] = i2s_data;
		end
		compare(name, {1'b0, exp, 15'd0, 1'b0, exp, 15'd0}, frame);
	endtask

	task automatic print_counts;
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
	endtask

endmodule

/* verification/pcw_board_stim.txt */
# kind name a b c d (hex). U: opcode, status, reset. S: word, status, reset
# K: flags code - ps2_key. M: flags x y ps2_mouse. W/C: addr data [rd_addr old]. R: addr data. A: mix sample
U unknown_opcode 7f 00000000 1 0
S status_word a5c30f02 a5c30f02 0 0
S status_reset 00000081 00000081 1 0
K key_press 02 1c 0 61c
K key_extended 03 75 0 375
K key_repeat 03 75 0 775
K key_release 00 1c 0 01c
M mouse_move 09 10 f0 1f01009
M mouse_again 08 00 05 0050008
W wr_a 005 3c 0 0
R rd_a 005 3c 0 0
W wr_b 1ff a7 0 0
R rd_b 1ff a7 0 0
W wr_c 100 55 0 0
R rd_c 100 55 0 0
C collide 0a0 99 005 3c
R rd_new 0a0 99 0 0
A audio_pos 05a ad00 0 0
A audio_neg 1c3 6180 0 0

/* verification/tb_pcw_board.sv */
`include "pcw_board_defs.svh"

module tb_pcw_board;

	logic clk_sys;
	logic reset;
	logic host_strobe;
	logic [7:0] host_byte;
	logic core_rd;
	logic [8:0] core_addr;
	logic [7:0] core_rd_data;
	logic core_rd_valid;
	logic [8:0] audio_mix;
	logic [31:0] status;
	logic core_reset;
	logic [10:0] ps2_key;
	logic [24:0] ps2_mouse;
	logic i2s_bck;
	logic i2s_lrck;
	logic i2s_data;

	string kinds[$];
	string names[$];
	logic [31:0] fa[$];
	logic [31:0] fb[$];
	logic [31:0] fc[$];
	logic [31:0] fd[$];

	pcw_board pcw_board_inst (.*);

	pcw_board_checker checker_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Idle gap of zero to two cycles after each byte unless told otherwise
	task automatic send_byte(input logic [7:0] b, input bit no_gap);
		@(posedge clk_sys);
		host_strobe <= 1'b1;
		host_byte <= b;
		@(posedge clk_sys);
		host_strobe <= 1'b0;
		if (!no_gap)
			repeat ($urandom % 3) @(posedge clk_sys);
	endtask

	// Returns zero when the stimulus file cannot be opened
	function automatic bit read_file();
		int fd_in;
		string line;
		string k;
		string n;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd_in = $fopen("verification/pcw_board_stim.txt", "r");
		if (fd_in == 0)
			return 1'b0;
		while ($fgets(line, fd_in) > 0) begin
			if (line.len() < 3 || line[0] == "#")
				continue;
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			void'($sscanf(line, "%s %s %h %h %h %h", k, n, a, b, c, d));
			kinds.push_back(k);
			names.push_back(n);
			fa.push_back(a);
			fb.push_back(b);
			fc.push_back(c);
			fd.push_back(d);
		end
		$fclose(fd_in);
		return 1'b1;
	endfunction

	task automatic run_record(input int i);
		case (kinds[i])
			"U": begin
				send_byte(fa[i][7:0], 1'b1);
				checker_inst.check_status(names[i], fb[i], fc[i][0]);
			end
			"S": begin
				send_byte(`PCW_OP_STATUS, 1'b0);
				for (int j = 0; j < 3; j++)
					send_byte(fa[i][8*j +: 8], 1'b0);
				send_byte(fa[i][31:24], 1'b1);
				checker_inst.check_status(names[i], fb[i], fc[i][0]);
			end
			"K", "M": begin
				send_byte(kinds[i] == "K" ? `PCW_OP_KEY : `PCW_OP_MOUSE, 1'b0);
				send_byte(fa[i][7:0], 1'b0);
				if (kinds[i] == "M")
					send_byte(fb[i][7:0], 1'b0);
				send_byte(kinds[i] == "K" ? fb[i][7:0] : fc[i][7:0], 1'b1);
				checker_inst.check_event(names[i], kinds[i] == "M", fd[i][24:0]);
			end
			"W", "C": begin
				send_byte(`PCW_OP_SECTOR, 1'b0);
				send_byte({7'd0, fa[i][8]}, 1'b0);
				send_byte(fa[i][7:0], 1'b0);
				send_byte(fb[i][7:0], 1'b1);
				if (kinds[i] == "C") begin
					// Lands on the same cycle as the store's write strobe
					core_rd <= 1'b1;
					core_addr <= fc[i][8:0];
					fork
						checker_inst.check_read(names[i], fd[i][7:0]);
						begin
							@(posedge clk_sys);
							core_rd <= 1'b0;
						end
					join
				end
				repeat (3) @(posedge clk_sys);
			end
			"R": begin
				@(posedge clk_sys);
				core_rd <= 1'b1;
				core_addr <= fa[i][8:0];
				fork
					checker_inst.check_read(names[i], fb[i][7:0]);
					begin
						@(posedge clk_sys);
						core_rd <= 1'b0;
					end
				join
				@(posedge clk_sys);
			end
			"A": begin
				@(posedge clk_sys);
				audio_mix <= fa[i][8:0];
				repeat (2) @(posedge clk_sys);
				checker_inst.check_audio(names[i], fb[i][15:0]);
			end
			default: checker_inst.report_missing(names[i], "the record kind is not known");
		endcase
	endtask

	initial begin
		int audio_tests;
		longint limit;
		reset = 1'b1;
		host_strobe = 1'b0;
		host_byte = 8'd0;
		core_rd = 1'b0;
		core_addr = 9'd0;
		audio_mix = 9'd0;
		void'($urandom(32'hb161_5088));
		if (!read_file()) begin
			$display("Cannot open the stimulus file");
			$display("TEST FAIL");
			$finish;
		end else begin
			audio_tests = 0;
			foreach (kinds[i])
				if (kinds[i] == "A")
					audio_tests++;
			limit = kinds.size() * 400 + audio_tests * 2 * 64 * 2 * `PCW_I2S_BCK_DIV;
			fork
				begin
					repeat (limit) @(posedge clk_sys);
					$display("Timeout after %0d cycles, the tests did not finish", limit);
					$display("TEST FAIL");
					$finish;
				end
			join_none
			repeat (4) @(posedge clk_sys);
			reset <= 1'b0;
			foreach (kinds[i])
				run_record(i);
			checker_inst.print_counts();
			if (checker_inst.fail_count == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

endmodule

/* verilog/audio_i2s.sv */
`include "pcw_board_defs.svh"

module audio_i2s (
	input logic clk_sys,
	input logic reset,
	input logic [8:0] audio_mix,
	output logic i2s_bck,
	output logic i2s_lrck,
	output logic i2s_data
);

	localparam int DIV_W = $clog2(`PCW_I2S_BCK_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic half_tick;
	logic bck_fall;
	logic [5:0] bit_cnt; // Bit clock position within the 64-slot frame
	logic [5:0] next_cnt;
	logic [15:0] new_sample;
	logic [15:0] sample_q;
	logic [31:0] shreg;

	assign half_tick = (div_cnt == DIV_W'(`PCW_I2S_BCK_DIV - 1));
	assign bck_fall = half_tick & i2s_bck;
	assign next_cnt = bit_cnt + 6'd1;

	// Signed 9-bit mix to offset binary, left aligned in 16 bits
	assign new_sample = {~audio_mix[8], audio_mix[7:0], 7'b0000000};

	assign i2s_data = shreg[31];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			i2s_bck <= 1'b0;
		end else if (half_tick) begin
			div_cnt <= '0;
			i2s_bck <= ~i2s_bck;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Data and word select change on the falling bit clock edge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bit_cnt <= 6'd63; // First falling edge opens a fresh frame
			i2s_lrck <= 1'b0;
			shreg <= 32'd0;
		end else if (bck_fall) begin
			bit_cnt <= next_cnt;
			i2s_lrck <= next_cnt[5];
			if (next_cnt[4:0] == 5'd0) begin
				// Slot 0 carries a zero, the MSB follows one bit clock later
				if (next_cnt[5] == 1'b0)
					shreg <= {1'b0, new_sample, 15'd0};
				else
					shreg <= {1'b0, sample_q, 15'd0}; // Right channel repeats the left
			end else begin
				shreg <= {shreg[30:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (bck_fall && next_cnt == 6'd0)
			sample_q <= new_sample;
	end

endmodule

/* verilog/event_toggle.sv */
module event_toggle #(
	parameter type payload_t = logic [7:0]
) (
	input logic clk_sys,
	input logic reset,
	input logic event_strobe,
	input payload_t event_payload,
	output logic level,
	output payload_t payload
);

	// The core spots a new event by comparing level with its last copy,
	// so two identical events in a row still register as two
	always_ff @(posedge clk_sys) begin
		if (reset)
			level <= 1'b0;
		else if (event_strobe)
			level <= ~level;
	end

	always_ff @(posedge clk_sys) begin
		if (event_strobe)
			payload <= event_payload; // Held until the next event
	end

endmodule

/* verilog/host_link.sv */
`include "pcw_board_defs.svh"

module host_link (
	input logic clk_sys,
	input logic reset,
	input logic host_strobe,
	input pcw_board_pkg::byte_t host_byte,
	output logic [31:0] status,
	output logic core_reset,
	output logic key_strobe,
	output pcw_board_pkg::key_payload_t key_payload,
	output logic mouse_strobe,
	output pcw_board_pkg::mouse_payload_t mouse_payload,
	output logic wr_strobe,
	output pcw_board_pkg::sector_addr_t wr_addr,
	output pcw_board_pkg::byte_t wr_data
);
	import pcw_board_pkg::*;

	byte_t opcode;
	logic in_frame;
	logic [2:0] count; // Payload bytes taken so far
	logic [31:0] shift;
	logic [31:0] frame_data;
	logic [2:0] frame_len;
	logic last_byte;

	// Payload length of an opcode, zero when the opcode is not known
	function automatic logic [2:0] len_of(byte_t op);
		case (op)
			`PCW_OP_STATUS: len_of = `PCW_LEN_STATUS;
			`PCW_OP_KEY: len_of = `PCW_LEN_KEY;
			`PCW_OP_MOUSE: len_of = `PCW_LEN_MOUSE;
			`PCW_OP_SECTOR: len_of = `PCW_LEN_SECTOR;
			default: len_of = 3'd0;
		endcase
	endfunction

	// New bytes enter at the top so the first byte ends up lowest
	assign frame_data = {host_byte, shift[31:8]};
	assign frame_len = len_of(opcode);
	assign last_byte = host_strobe & in_frame & (count == frame_len - 3'd1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			opcode <= '0;
			in_frame <= 1'b0;
			count <= 3'd0;
			status <= 32'd0;
			core_reset <= 1'b1; // Core stays in reset until the host sends a status word
			key_strobe <= 1'b0;
			mouse_strobe <= 1'b0;
			wr_strobe <= 1'b0;
		end else begin
			key_strobe <= 1'b0;
			mouse_strobe <= 1'b0;
			wr_strobe <= 1'b0;
			if (host_strobe) begin
				if (!in_frame) begin
					if (len_of(host_byte) != 3'd0) begin // An unknown opcode is simply skipped
						opcode <= host_byte;
						in_frame <= 1'b1;
						count <= 3'd0;
					end
				end else if (last_byte) begin
					in_frame <= 1'b0;
					case (opcode)
						`PCW_OP_STATUS: begin
							status <= frame_data;
							core_reset <= frame_data[0];
						end
						`PCW_OP_KEY: key_strobe <= 1'b1;
						`PCW_OP_MOUSE: mouse_strobe <= 1'b1;
						`PCW_OP_SECTOR: wr_strobe <= 1'b1;
						default: in_frame <= 1'b0;
					endcase
				end else begin
					count <= count + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (host_strobe && in_frame)
			shift <= frame_data;
		if (last_byte) begin
			// Key frame leaves the code on top and the flags byte below it
			key_payload <= '{pressed: frame_data[17], extended: frame_data[16],
				code: frame_data[31:24]};
			mouse_payload <= '{y: frame_data[31:24], x: frame_data[23:16],
				flags: frame_data[15:8]};
			wr_addr <= {frame_data[8], frame_data[23:16]};
			wr_data <= frame_data[31:24];
		end
	end

	a_one_command: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({key_strobe, mouse_strobe, wr_strobe}));

endmodule

/* verilog/pcw_board.sv */
module pcw_board (
	input logic clk_sys,
	input logic reset,
	input logic host_strobe,
	input pcw_board_pkg::byte_t host_byte,
	input logic core_rd,
	input pcw_board_pkg::sector_addr_t core_addr,
	output pcw_board_pkg::byte_t core_rd_data,
	output logic core_rd_valid,
	input logic [8:0] audio_mix,
	output logic [31:0] status,
	output logic core_reset,
	output logic [10:0] ps2_key,
	output logic [24:0] ps2_mouse,
	output logic i2s_bck,
	output logic i2s_lrck,
	output logic i2s_data
);
	import pcw_board_pkg::*;

	logic key_strobe;
	key_payload_t key_payload;
	logic key_level;
	key_payload_t key_out;

	logic mouse_strobe;
	mouse_payload_t mouse_payload;
	logic mouse_level;
	mouse_payload_t mouse_out;

	logic wr_strobe;
	sector_addr_t wr_addr;
	byte_t wr_data;

	host_link host_link_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.host_strobe(host_strobe),
		.host_byte(host_byte),
		.status(status),
		.core_reset(core_reset),
		.key_strobe(key_strobe),
		.key_payload(key_payload),
		.mouse_strobe(mouse_strobe),
		.mouse_payload(mouse_payload),
		.wr_strobe(wr_strobe),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	event_toggle #(.payload_t(key_payload_t)) key_toggle (
		.clk_sys(clk_sys),
		.reset(reset),
		.event_strobe(key_strobe),
		.event_payload(key_payload),
		.level(key_level),
		.payload(key_out)
	);

	event_toggle #(.payload_t(mouse_payload_t)) mouse_toggle (
		.clk_sys(clk_sys),
		.reset(reset),
		.event_strobe(mouse_strobe),
		.event_payload(mouse_payload),
		.level(mouse_level),
		.payload(mouse_out)
	);

	// Level bit on top, as the core expects
	assign ps2_key = {key_level, key_out};
	assign ps2_mouse = {mouse_level, mouse_out};

	sector_store sector_store_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.wr_strobe(wr_strobe),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.core_rd(core_rd),
		.core_addr(core_addr),
		.core_rd_data(core_rd_data),
		.core_rd_valid(core_rd_valid)
	);

	audio_i2s audio_i2s_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.audio_mix(audio_mix),
		.i2s_bck(i2s_bck),
		.i2s_lrck(i2s_lrck),
		.i2s_data(i2s_data)
	);

endmodule

/* verilog/pcw_board_defs.svh */
`ifndef PCW_BOARD_DEFS_SVH
`define PCW_BOARD_DEFS_SVH

// Opcode bytes that open a host frame
`define PCW_OP_STATUS 8'h1E
`define PCW_OP_KEY 8'h04
`define PCW_OP_MOUSE 8'h05
`define PCW_OP_SECTOR 8'h20

// Payload bytes that follow each opcode
`define PCW_LEN_STATUS 3'd4 // Status word, least significant byte first
`define PCW_LEN_KEY 3'd2 // Flags, then the scan code
`define PCW_LEN_MOUSE 3'd3 // Flags, x, y
`define PCW_LEN_SECTOR 3'd3 // Address high, address low, data

// Size of the disk sector store in bytes
`define PCW_SECTOR_BYTES 512

// clk_sys cycles per half period of the I2S bit clock
`define PCW_I2S_BCK_DIV 4

`endif

/* verilog/pcw_board_pkg.sv */
package pcw_board_pkg;

	// One byte as it travels on the host link and out of the sector store
	typedef logic [7:0] byte_t;

	// Byte address inside the 512-byte sector
	typedef logic [8:0] sector_addr_t;

	// Key event in the order the core reads it from ps2_key
	typedef struct packed {
		logic pressed;
		logic extended;
		byte_t code;
	} key_payload_t;

	// Mouse event in the order the core reads it from ps2_mouse
	typedef struct packed {
		byte_t y; // Movement since the last event
		byte_t x;
		byte_t flags; // Buttons and sign bits as the host sends them
	} mouse_payload_t;

endpackage

/* verilog/sector_store.sv */
`include "pcw_board_defs.svh"

module sector_store (
	input logic clk_sys,
	input logic reset,
	input logic wr_strobe,
	input pcw_board_pkg::sector_addr_t wr_addr,
	input pcw_board_pkg::byte_t wr_data,
	input logic core_rd,
	input pcw_board_pkg::sector_addr_t core_addr,
	output pcw_board_pkg::byte_t core_rd_data,
	output logic core_rd_valid
);
	import pcw_board_pkg::*;

	byte_t mem [`PCW_SECTOR_BYTES];

	// Requests are registered first and arbitrated a cycle later
	logic wr_req_q;
	sector_addr_t wr_addr_q;
	byte_t wr_data_q;
	logic rd_req_q;
	sector_addr_t rd_addr_q;

	// A read that lost to a write waits here for one cycle
	logic hold_full;
	sector_addr_t hold_addr;

	logic rd_pending;
	sector_addr_t rd_pend_addr;
	logic grant_wr;
	logic grant_rd;

	assign rd_pending = hold_full | rd_req_q;
	assign rd_pend_addr = hold_full ? hold_addr : rd_addr_q;
	assign grant_wr = wr_req_q; // Host writes always win
	assign grant_rd = rd_pending & ~wr_req_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_req_q <= 1'b0;
			rd_req_q <= 1'b0;
			hold_full <= 1'b0;
			core_rd_valid <= 1'b0;
		end else begin
			wr_req_q <= wr_strobe;
			rd_req_q <= core_rd;
			core_rd_valid <= grant_rd;
			if (wr_req_q && rd_req_q)
				hold_full <= 1'b1;
			else if (grant_rd)
				hold_full <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		wr_addr_q <= wr_addr;
		wr_data_q <= wr_data;
		rd_addr_q <= core_addr;
		if (wr_req_q && rd_req_q)
			hold_addr <= rd_addr_q;
	end

	// Single port, one access per cycle
	always_ff @(posedge clk_sys) begin
		if (grant_wr)
			mem[wr_addr_q] <= wr_data_q;
		else if (grant_rd)
			core_rd_data <= mem[rd_pend_addr];
	end

	// The core spaces its reads, which is what lets the hold register suffice
	a_read_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		core_rd |=> !core_rd);

	a_hold_free: assert property (@(posedge clk_sys) disable iff (reset)
		(wr_req_q && rd_req_q) |-> !hold_full);

endmodule
